/* lsu_decode.sv */
// Load/store decoder with byte mask, lane alignment, region select and misalign flag
`timescale 1ns/10ps

module lsu_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mem_access_pkg::opcode_t opcode,
    input  mem_access_pkg::funct3_t funct3,
    input  mem_access_pkg::addr_t   addr,
    input  mem_access_pkg::word_t   wdata,
    output logic                    misalign,
    mem_req_if.producer             enq
);
    import mem_access_pkg::*;

    logic  is_store;
    logic  is_load;
    logic  io_hit;
    logic  dmem_hit;
    logic  imem_hit;
    logic  sh_bad;
    logic  keep;
    be_t   st_mask;
    word_t st_data;

    // ----------------------------------------
    // Access classification
    // ----------------------------------------

    assign is_store = (opcode == OPC_STORE);
    assign is_load  = (opcode == OPC_LOAD);

    assign io_hit   = (addr[31:28] == IO_REGION);
    assign dmem_hit = ~addr[31] & addr[28];
    assign imem_hit = ~addr[31] & addr[29];

    // Halfword at an odd byte address has no lane pair
    assign sh_bad = is_store && (funct3 == FNC_SH) && addr[0];

    // ----------------------------------------
    // Store byte mask and lane alignment
    // ----------------------------------------

    always_comb
    begin
        case (funct3)
            FNC_SB:
            begin
                st_mask = 4'b0001 << addr[1:0];
                st_data = wdata << {addr[1:0], 3'b000};
            end
            FNC_SH:
            begin
                st_mask = addr[1] ? 4'b1100 : 4'b0011;
                st_data = wdata << {addr[1:0], 3'b000};
            end
            default:
            begin
                // Word store ignores the low address bits
                st_mask = 4'b1111;
                st_data = wdata;
            end
        endcase
    end

    // Only IO loads and stores that hit a region survive
    assign keep = (is_load && io_hit) ||
                  (is_store && (dmem_hit || imem_hit || io_hit) && !sh_bad);

    // Request toward the queue, written on the strobe edge
    assign enq.valid   = req_valid && keep;
    assign enq.addr    = addr;
    assign enq.wdata   = is_load ? '0 : st_data;
    assign enq.mask    = is_load ? '0 : st_mask;
    assign enq.to_dmem = is_store && dmem_hit;
    assign enq.to_imem = is_store && imem_hit;
    assign enq.to_io   = io_hit;
    assign enq.is_load = is_load;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            misalign <= 1'b0;
        end
        else
        begin
            misalign <= req_valid && sh_bad;
        end
    end

endmodule

/* mem_access.f */
mem_access_pkg.sv
mem_req_if.sv
lsu_decode.sv
mem_req_fifo.sv
mem_port_router.sv
mem_access.sv
tb_mem_access.sv

/* mem_access.sv */
// Top level of the memory request path with decoder, request queue and port router
`timescale 1ns/10ps

module mem_access (
    input  logic                    clk,
    input  logic                    rst_n,

    // Request from the execute stage
    input  logic                    req_valid,
    input  mem_access_pkg::opcode_t opcode,
    input  mem_access_pkg::funct3_t funct3,
    input  mem_access_pkg::addr_t   addr,
    input  mem_access_pkg::word_t   wdata,
    output logic                    req_full,
    output logic                    misalign,

    // Memory and IO side
    input  logic                    io_busy,
    output mem_access_pkg::be_t     dmem_we,
    output mem_access_pkg::be_t     imem_we,
    output mem_access_pkg::be_t     io_trans,
    output logic                    io_recv,
    output mem_access_pkg::addr_t   mem_addr,
    output mem_access_pkg::word_t   mem_wdata
);

    // Decoder to queue, and queue head to router
    mem_req_if enq_bus ();
    mem_req_if deq_bus ();

    lsu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .opcode    (opcode),
        .funct3    (funct3),
        .addr      (addr),
        .wdata     (wdata),
        .misalign  (misalign),
        .enq       (enq_bus.producer)
    );

    mem_req_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .enq   (enq_bus.consumer),
        .deq   (deq_bus.producer),
        .full  (req_full)
    );

    mem_port_router u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .io_busy   (io_busy),
        .deq       (deq_bus.consumer),
        .dmem_we   (dmem_we),
        .imem_we   (imem_we),
        .io_trans  (io_trans),
        .io_recv   (io_recv),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

/* mem_access_pkg.sv */
// Opcode and funct3 constants, queue depth and vector types for the memory request path
package mem_access_pkg;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    // Byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // One enable bit per byte lane, bit i for byte i
    typedef logic [3:0] be_t;

    // Instruction fields seen by the decoder
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // ----------------------------------------
    // Instruction encodings
    // ----------------------------------------

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Store widths
    localparam funct3_t FNC_SB = 3'd0;
    localparam funct3_t FNC_SH = 3'd1;
    localparam funct3_t FNC_SW = 3'd2;

    // ----------------------------------------
    // Queue and address map
    // ----------------------------------------

    // Number of request entries held between decoder and router
    localparam int REQ_DEPTH = 8;

    // Read and write pointer into the request queue
    typedef logic [$clog2(REQ_DEPTH)-1:0] qptr_t;

    // Value of A[31:28] that selects the IO region
    localparam logic [3:0] IO_REGION = 4'b1000;

endpackage

/* mem_port_router.sv */
// Port router that pops queued requests into registered enable and receive pulses
`timescale 1ns/10ps

module mem_port_router (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  io_busy,
    mem_req_if.consumer           deq,
    output mem_access_pkg::be_t   dmem_we,
    output mem_access_pkg::be_t   imem_we,
    output mem_access_pkg::be_t   io_trans,
    output logic                  io_recv,
    output mem_access_pkg::addr_t mem_addr,
    output mem_access_pkg::word_t mem_wdata
);
    import mem_access_pkg::*;

    logic io_stall;
    logic take;

    // ----------------------------------------
    // Head acceptance
    // ----------------------------------------

    // IO head waits while the IO side is busy, blocking everything behind it
    assign io_stall = deq.to_io && io_busy;
    assign take     = deq.valid && !io_stall;
    assign deq.pop  = take;

    // ----------------------------------------
    // Port pulses
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dmem_we  <= '0;
            imem_we  <= '0;
            io_trans <= '0;
            io_recv  <= 1'b0;
        end
        else if (take)
        begin
            // Same mask goes to every region the request hits
            dmem_we  <= deq.to_dmem ? deq.mask : '0;
            imem_we  <= deq.to_imem ? deq.mask : '0;
            io_trans <= (deq.to_io && !deq.is_load) ? deq.mask : '0;
            io_recv  <= deq.is_load;
        end
        else
        begin
            dmem_we  <= '0;
            imem_we  <= '0;
            io_trans <= '0;
            io_recv  <= 1'b0;
        end
    end

    // Address and data hold between requests
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            mem_addr  <= deq.addr;
            mem_wdata <= deq.wdata;
        end
    end

endmodule

/* mem_req_fifo.sv */
// Circular request queue with full level and head presented on the dequeue bus
`timescale 1ns/10ps

module mem_req_fifo (
    input  logic        clk,
    input  logic        rst_n,
    mem_req_if.consumer enq,
    mem_req_if.producer deq,
    output logic        full
);
    import mem_access_pkg::*;

    // Entry storage, flags packed as {is_load, to_io, to_imem, to_dmem}
    addr_t      addr_mem  [REQ_DEPTH];
    word_t      data_mem  [REQ_DEPTH];
    be_t        mask_mem  [REQ_DEPTH];
    logic [3:0] flag_mem  [REQ_DEPTH];

    qptr_t                      wr_ptr;
    qptr_t                      rd_ptr;
    logic [$clog2(REQ_DEPTH):0] count;
    logic                       empty;
    logic                       wr_en;
    logic                       rd_en;

    assign full  = (count == REQ_DEPTH);
    assign empty = (count == '0);

    // A push while full is dropped
    assign wr_en   = enq.valid && !full;
    assign rd_en   = deq.pop && !empty;
    assign enq.pop = wr_en;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            addr_mem[wr_ptr] <= enq.addr;
            data_mem[wr_ptr] <= enq.wdata;
            mask_mem[wr_ptr] <= enq.mask;
            flag_mem[wr_ptr] <= {enq.is_load, enq.to_io, enq.to_imem, enq.to_dmem};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + wr_en - rd_en;
        end
    end

    // Head of queue, visible as soon as it is written
    assign deq.valid   = !empty;
    assign deq.addr    = addr_mem[rd_ptr];
    assign deq.wdata   = data_mem[rd_ptr];
    assign deq.mask    = mask_mem[rd_ptr];
    assign deq.to_dmem = flag_mem[rd_ptr][0];
    assign deq.to_imem = flag_mem[rd_ptr][1];
    assign deq.to_io   = flag_mem[rd_ptr][2];
    assign deq.is_load = flag_mem[rd_ptr][3];

endmodule

/* mem_req_if.sv */
// Decoded memory request bus with producer and consumer views
`timescale 1ns/10ps

interface mem_req_if;
    import mem_access_pkg::*;

    // Push strobe on the enqueue side, not-empty level on the dequeue side
    logic  valid;
    addr_t addr;
    // Already shifted onto its byte lanes
    word_t wdata;
    be_t   mask;
    // Region bits, dmem and imem may both be set
    logic  to_dmem;
    logic  to_imem;
    logic  to_io;
    logic  is_load;

    // Returned by the consumer when it takes the request
    logic  pop;

    modport producer (
        output valid, addr, wdata, mask, to_dmem, to_imem, to_io, is_load,
        input  pop
    );

    modport consumer (
        input  valid, addr, wdata, mask, to_dmem, to_imem, to_io, is_load,
        output pop
    );

endinterface

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f mem_access.f \
    --top-module tb_mem_access -o sim_mem_access &&
./obj_dir/sim_mem_access > sim.log 2>&1 || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_mem_access.sv */
// Testbench for the memory request path with reference model, random traffic and in-order compare
`timescale 1ns/10ps

module tb_mem_access;
    import mem_access_pkg::*;

    localparam int NUM_REQ    = 400;
    localparam int MAX_CYCLES = 4 * NUM_REQ + 200;

    // Expected port activity for one request
    typedef struct packed {
        logic        kept;
        logic        mis;
        be_t         dmem;
        be_t         imem;
        be_t         io;
        logic        recv;
        addr_t       addr;
        word_t       data;
        logic        iso;
        logic [31:0] edge_cyc;
    } exp_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    req_valid;
    logic    io_busy;
    logic    req_full;
    logic    misalign;
    logic    io_recv;
    opcode_t opcode;
    funct3_t funct3;
    addr_t   addr;
    addr_t   mem_addr;
    word_t   wdata;
    word_t   mem_wdata;
    be_t     dmem_we;
    be_t     imem_we;
    be_t     io_trans;

    exp_t exp_q[$];
    exp_t head;
    logic cur_mis;
    logic mis_exp;
    logic busy_rand;
    int   cycle;
    int   value_errs;
    int   other_errs;

    always #4 clk = ~clk;

    mem_access u_mem_access (.*);

    // Expected result from the load/store rules
    function automatic exp_t expected_result(opcode_t op, funct3_t f3, addr_t a, word_t d);
        exp_t  r;
        be_t   m;
        word_t sd;
        logic  dm;
        logic  im;
        logic  io;
        r  = '0;
        dm = (a[31] == 1'b0) && a[28];
        im = (a[31] == 1'b0) && a[29];
        io = (a[31:28] == 4'b1000);
        if (op == OPC_LOAD)
        begin
            r.kept = io;
            r.recv = io;
            r.addr = a;
        end
        else if (op == OPC_STORE)
        begin
            m  = 4'b1111;
            sd = d;
            if (f3 == FNC_SB)
            begin
                m  = be_t'(1 << a[1:0]);
                sd = d << (8 * a[1:0]);
            end
            else if (f3 == FNC_SH)
            begin
                r.mis = a[0];
                m     = a[1] ? 4'b1100 : 4'b0011;
                sd    = d << (8 * a[1:0]);
            end
            r.kept = !r.mis && (dm || im || io);
            r.dmem = dm ? m : 4'b0000;
            r.imem = im ? m : 4'b0000;
            r.io   = io ? m : 4'b0000;
            r.addr = a;
            r.data = sd;
        end
        return r;
    endfunction

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (busy_rand)
            io_busy = ($urandom % 4 == 0);
    endtask

    task automatic send_request(opcode_t op, funct3_t f3, addr_t a, word_t d, logic iso);
        exp_t e;
        while (req_full)
            next_cycle();
        e          = expected_result(op, f3, a, d);
        e.iso      = iso;
        e.edge_cyc = cycle + 1;
        if (e.kept)
            exp_q.push_back(e);
        req_valid = 1'b1;
        opcode    = op;
        funct3    = f3;
        addr      = a;
        wdata     = d;
        cur_mis   = e.mis;
        next_cycle();
        req_valid = 1'b0;
        cur_mis   = 1'b0;
    endtask

    task automatic send_random_request();
        int      pick;
        opcode_t op;
        addr_t   base;
        pick = $urandom % 20;
        op   = (pick < 12) ? OPC_STORE : (pick < 17) ? OPC_LOAD : 7'b0010011;
        case ($urandom % 5)
            0:       base = 32'h1000_0000;
            1:       base = 32'h2000_0000;
            2:       base = 32'h3000_0000;
            3:       base = 32'h8000_0000;
            default: base = 32'h4000_0000;
        endcase
        send_request(op, funct3_t'($urandom % 3), base | ($urandom & 32'hFFF), $urandom, 1'b0);
        if ($urandom % 4 == 0)
            next_cycle();
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0)
            next_cycle();
        repeat (3) next_cycle();
    endtask

    // ----------------------------------------
    // Checking
    // ----------------------------------------

    always @(posedge clk)
    begin
        mis_exp <= req_valid && cur_mis;
        cycle++;
        if (cycle >= MAX_CYCLES)
        begin
            $display("Run stopped at cycle %0d, the request queue never drained", cycle);
            $display("Finished: %0d value errors, %0d other errors", value_errs, other_errs);
            $display("Test failed");
            $finish;
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (misalign === mis_exp)
            else
            begin
                value_errs++;
                $display("Error at %0t: misalign %b, expected %b", $time, misalign, mis_exp);
            end
            if ({dmem_we, imem_we, io_trans, io_recv} != '0)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    other_errs++;
                    $display("A port pulse appeared at %0t with no request outstanding", $time);
                end
                if (exp_q.size() > 0)
                begin
                    head = exp_q.pop_front();
                    assert ({dmem_we, imem_we, io_trans, io_recv} ===
                            {head.dmem, head.imem, head.io, head.recv})
                    else
                    begin
                        value_errs++;
                        $display("Error at %0t: enables %h %h %h recv %b, expected %h %h %h %b",
                                 $time, dmem_we, imem_we, io_trans, io_recv,
                                 head.dmem, head.imem, head.io, head.recv);
                    end
                    assert (mem_addr === head.addr && (head.recv || mem_wdata === head.data))
                    else
                    begin
                        value_errs++;
                        $display("Error at %0t: addr %h data %h, expected %h %h",
                                 $time, mem_addr, mem_wdata, head.addr, head.data);
                    end
                    assert (!head.iso || cycle == head.edge_cyc + 1)
                    else
                    begin
                        value_errs++;
                        $display("Error at %0t: pulse at cycle %0d, expected %0d",
                                 $time, cycle, head.edge_cyc + 1);
                    end
                end
            end
        end
    end

    initial
    begin
        void'($urandom(16));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        opcode     = '0;
        funct3     = '0;
        addr       = '0;
        wdata      = '0;
        io_busy    = 1'b0;
        cur_mis    = 1'b0;
        busy_rand  = 1'b0;
        cycle      = 0;
        value_errs = 0;
        other_errs = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        assert ({dmem_we, imem_we, io_trans, io_recv, misalign, req_full} == '0)
        else
        begin
            value_errs++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end

        // Lane masks and the latency of the first request on an empty queue
        for (int k = 0; k < 4; k++)
            send_request(OPC_STORE, FNC_SB, 32'h1000_0100 + k, 32'hA1B2_C3D4, k == 0);
        send_request(OPC_STORE, FNC_SH, 32'h1000_0200, 32'h1122_3344, 1'b0);
        send_request(OPC_STORE, FNC_SH, 32'h1000_0202, 32'h5566_7788, 1'b0);
        send_request(OPC_STORE, FNC_SW, 32'h1000_0303, 32'h99AA_BBCC, 1'b0);
        // Regions, IO loads and dropped accesses
        send_request(OPC_STORE, FNC_SW, 32'h2000_0010, 32'h0BAD_F00D, 1'b0);
        send_request(OPC_STORE, FNC_SH, 32'h3000_0012, 32'h0000_BEEF, 1'b0);
        send_request(OPC_STORE, FNC_SB, 32'h8000_0021, 32'h0000_005A, 1'b0);
        send_request(OPC_STORE, FNC_SW, 32'h4000_0000, 32'hDEAD_BEEF, 1'b0);
        send_request(OPC_LOAD, FNC_SW, 32'h1000_0040, 32'h0, 1'b0);
        send_request(OPC_LOAD, FNC_SW, 32'h8000_0040, 32'h0, 1'b0);
        send_request(OPC_STORE, FNC_SH, 32'h1000_0001, 32'h1234_5678, 1'b0);
        send_request(OPC_STORE, FNC_SH, 32'h1000_0003, 32'h1234_5678, 1'b0);
        send_request(7'b0110011, FNC_SW, 32'h1000_0000, 32'h1234_5678, 1'b0);
        wait_drain();

        // Fill the queue behind a busy IO side
        io_busy = 1'b1;
        for (int k = 0; k < REQ_DEPTH; k++)
            send_request(OPC_STORE, FNC_SW, 32'h8000_0100 + 4 * k, $urandom, 1'b0);
        assert (req_full === 1'b1)
        else
        begin
            other_errs++;
            $display("req_full stayed low with %0d requests queued", REQ_DEPTH);
        end
        repeat (2) next_cycle();
        io_busy = 1'b0;
        wait_drain();
        assert (req_full === 1'b0)
        else
        begin
            other_errs++;
            $display("req_full stayed high after the queue drained");
        end

        busy_rand = 1'b1;
        for (int n = 0; n < NUM_REQ; n++)
            send_random_request();
        busy_rand = 1'b0;
        io_busy   = 1'b0;
        wait_drain();

        $display("Finished: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
